// File: logic/muscle_link_pkg.sv
package muscle_link_pkg;

    //////////////////////////////
    // word types
    //////////////////////////////

    // length, gain, payload and apb data
    typedef logic [31:0] word_t;
    // spikes seen in one tick window
    typedef logic [31:0] count_t;
    // tick half period in ep50trig cycles
    typedef logic [17:0] half_t;
    // apb byte address
    typedef logic [7:0] addr_t;

    //////////////////////////////
    // apb register map
    //////////////////////////////

    localparam addr_t REG_GAIN      = 8'h00;
    localparam addr_t REG_TICK_HALF = 8'h04;
    localparam addr_t REG_CTRL      = 8'h08;
    // read only copy of the last received length
    localparam addr_t REG_LENGTH    = 8'h0C;

    localparam word_t GAIN_RESET      = 32'd0;
    localparam half_t TICK_HALF_RESET = 18'd1024;
    // run lives in bit 0 and starts off
    localparam word_t CTRL_RESET      = 32'd0;

    //////////////////////////////
    // spi link
    //////////////////////////////

    // master sck half period in clocks
    localparam int SPI_HALF_CLKS = 13;
    localparam int SPI_BITS      = 32;
    localparam int SYNC_STAGES   = 2;

    // bit counter holds 0..SPI_BITS plus overflow room
    localparam int BIT_CNT_W = $clog2(SPI_BITS) + 1;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
    typedef logic [$clog2(SPI_HALF_CLKS)-1:0] spi_div_t;

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_t;

endpackage

// File: logic/apb_if.sv
interface apb_if;

    // request side
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    muscle_link_pkg::addr_t paddr;
    muscle_link_pkg::word_t pwdata;

    // response side
    muscle_link_pkg::word_t prdata;
    logic                   pready;
    logic                   pslverr;

    // host side
    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    // register bank side
    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// File: logic/param_regs.sv
module param_regs (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    apb_if.slave                   bus,
    input  muscle_link_pkg::word_t length,
    output muscle_link_pkg::word_t gain,
    output muscle_link_pkg::half_t tick_half,
    output logic                   run
);

    logic                   access;
    logic                   addr_ok;
    logic                   err;
    muscle_link_pkg::word_t rd_data;

    //////////////////////////////
    // decode
    //////////////////////////////

    // second cycle of a transfer, no wait states
    assign access = bus.psel & bus.penable;

    // read mux and address check
    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (bus.paddr)
            muscle_link_pkg::REG_GAIN: begin
                rd_data = gain;
            end
            muscle_link_pkg::REG_TICK_HALF: begin
                rd_data = muscle_link_pkg::word_t'(tick_half);
            end
            muscle_link_pkg::REG_CTRL: begin
                rd_data = {31'd0, run};
            end
            // live value straight from the receiver
            muscle_link_pkg::REG_LENGTH: begin
                rd_data = length;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    // unmapped, or write to the read only length
    assign err = ~addr_ok | (bus.pwrite & (bus.paddr == muscle_link_pkg::REG_LENGTH));

    assign bus.pready  = 1'b1;
    assign bus.pslverr = access & err;
    // zero on errors and writes
    assign bus.prdata  = (access & ~bus.pwrite & ~err) ? rd_data : '0;

    //////////////////////////////
    // registers
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            gain      <= muscle_link_pkg::GAIN_RESET;
            tick_half <= muscle_link_pkg::TICK_HALF_RESET;
            run       <= muscle_link_pkg::CTRL_RESET[0];
        end else if (access && bus.pwrite && !err) begin
            // update lands at the end of the access cycle
            case (bus.paddr)
                muscle_link_pkg::REG_GAIN: begin
                    gain <= bus.pwdata;
                end
                muscle_link_pkg::REG_TICK_HALF: begin
                    tick_half <= bus.pwdata[$bits(muscle_link_pkg::half_t)-1:0];
                end
                muscle_link_pkg::REG_CTRL: begin
                    run <= bus.pwdata[0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: logic/sim_tick_gen.sv
module sim_tick_gen (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   run,
    input  muscle_link_pkg::half_t tick_half,
    output logic                   tick
);

    muscle_link_pkg::half_t cnt;
    // second half of the slow period
    logic                   phase;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt   <= '0;
            phase <= 1'b0;
            tick  <= 1'b0;
        end else if (!run || tick_half == '0) begin
            // held clear so the next run starts cleanly
            cnt   <= '0;
            phase <= 1'b0;
            tick  <= 1'b0;
        end else if (cnt == '0) begin
            // half period boundary
            cnt   <= tick_half - muscle_link_pkg::half_t'(1);
            phase <= ~phase;
            // one pulse per full period at the end of the second half
            tick  <= phase;
        end else begin
            cnt  <= cnt - muscle_link_pkg::half_t'(1);
            tick <= 1'b0;
        end
    end

endmodule

// File: logic/spike_counter.sv
module spike_counter (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    run,
    input  logic                    tick,
    input  logic                    mn_spike,
    output muscle_link_pkg::count_t window_count
);

    logic [muscle_link_pkg::SYNC_STAGES-1:0] spike_sync;
    logic                                    spike_prev;
    logic                                    rise;
    muscle_link_pkg::count_t                 count;

    // spike comes from another clock domain
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            spike_sync <= '0;
            spike_prev <= 1'b0;
        end else begin
            spike_sync <= {spike_sync[muscle_link_pkg::SYNC_STAGES-2:0], mn_spike};
            spike_prev <= spike_sync[muscle_link_pkg::SYNC_STAGES-1];
        end
    end

    assign rise = spike_sync[muscle_link_pkg::SYNC_STAGES-1] & ~spike_prev;

    // window accumulator
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            count        <= '0;
            window_count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (tick) begin
            // an edge on the tick cycle still belongs to this window
            window_count <= count + muscle_link_pkg::count_t'(rise);
            count        <= '0;
        end else begin
            count <= count + muscle_link_pkg::count_t'(rise);
        end
    end

endmodule

// File: logic/spi_length_rx.sv
module spi_length_rx (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   tick,
    input  logic                   sck,
    input  logic                   ssel,
    input  logic                   data,
    output muscle_link_pkg::word_t length
);

    logic [muscle_link_pkg::SYNC_STAGES-1:0] sck_sync;
    logic [muscle_link_pkg::SYNC_STAGES-1:0] ssel_sync;
    logic [muscle_link_pkg::SYNC_STAGES-1:0] data_sync;
    logic                                    sck_s;
    logic                                    ssel_s;
    logic                                    data_s;
    logic                                    sck_prev;
    logic                                    ssel_prev;
    logic                                    sck_rise;
    logic                                    ssel_rise;
    muscle_link_pkg::bit_cnt_t               bit_cnt;
    muscle_link_pkg::word_t                  shift;
    muscle_link_pkg::word_t                  staged;

    //////////////////////////////
    // oversample the spi pins
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sck_sync  <= '0;
            // select idles high
            ssel_sync <= '1;
            data_sync <= '0;
            sck_prev  <= 1'b0;
            ssel_prev <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[muscle_link_pkg::SYNC_STAGES-2:0], sck};
            ssel_sync <= {ssel_sync[muscle_link_pkg::SYNC_STAGES-2:0], ssel};
            data_sync <= {data_sync[muscle_link_pkg::SYNC_STAGES-2:0], data};
            sck_prev  <= sck_s;
            ssel_prev <= ssel_s;
        end
    end

    assign sck_s     = sck_sync[muscle_link_pkg::SYNC_STAGES-1];
    assign ssel_s    = ssel_sync[muscle_link_pkg::SYNC_STAGES-1];
    // data gets the same delay as sck
    assign data_s    = data_sync[muscle_link_pkg::SYNC_STAGES-1];
    assign sck_rise  = sck_s & ~sck_prev;
    assign ssel_rise = ssel_s & ~ssel_prev;

    //////////////////////////////
    // frame capture
    //////////////////////////////

    // msb first
    always_ff @(posedge ep50trig) begin
        if (!ssel_s && sck_rise) begin
            shift <= {shift[muscle_link_pkg::SPI_BITS-2:0], data_s};
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            bit_cnt <= '0;
            staged  <= '0;
            length  <= '0;
        end else begin
            if (ssel_rise) begin
                // keep only complete frames
                if (bit_cnt == muscle_link_pkg::bit_cnt_t'(muscle_link_pkg::SPI_BITS)) begin
                    staged <= shift;
                end
                bit_cnt <= '0;
            end else if (ssel_s) begin
                bit_cnt <= '0;
            end else if (sck_rise && bit_cnt != '1) begin
                // saturate so long frames never alias to 32
                bit_cnt <= bit_cnt + muscle_link_pkg::bit_cnt_t'(1);
            end
            // hand over to the sim side only on tick
            if (tick) begin
                length <= staged;
            end
        end
    end

endmodule

// File: logic/spi_rate_tx.sv
module spi_rate_tx (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    tick,
    input  muscle_link_pkg::count_t window_count,
    input  muscle_link_pkg::word_t  gain,
    output logic                    sck,
    output logic                    ssel,
    output logic                    data
);

    muscle_link_pkg::tx_state_t state;
    muscle_link_pkg::spi_div_t  div;
    muscle_link_pkg::bit_cnt_t  bit_cnt;
    muscle_link_pkg::word_t     shreg;
    muscle_link_pkg::word_t     payload;
    logic                       half_done;

    // scaled rate, low word of the product
    assign payload   = window_count * gain;
    assign half_done = (div == muscle_link_pkg::spi_div_t'(muscle_link_pkg::SPI_HALF_CLKS - 1));

    //////////////////////////////
    // frame state machine
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state   <= muscle_link_pkg::TX_IDLE;
            div     <= '0;
            bit_cnt <= '0;
            sck     <= 1'b0;
            ssel    <= 1'b1;
            data    <= 1'b0;
        end else begin
            case (state)
                muscle_link_pkg::TX_IDLE: begin
                    if (tick) begin
                        // select drops with the first bit already on the line
                        state   <= muscle_link_pkg::TX_SHIFT;
                        ssel    <= 1'b0;
                        data    <= payload[muscle_link_pkg::SPI_BITS-1];
                        div     <= '0;
                        bit_cnt <= '0;
                    end
                end
                muscle_link_pkg::TX_SHIFT: begin
                    // ticks in here are dropped
                    if (!half_done) begin
                        div <= div + muscle_link_pkg::spi_div_t'(1);
                    end else begin
                        div <= '0;
                        if (sck) begin
                            // falling edge moves to the next bit
                            sck     <= 1'b0;
                            bit_cnt <= bit_cnt + muscle_link_pkg::bit_cnt_t'(1);
                            data    <= shreg[muscle_link_pkg::SPI_BITS-2];
                        end else if (bit_cnt == muscle_link_pkg::bit_cnt_t'(
                                     muscle_link_pkg::SPI_BITS)) begin
                            // one half period after the last fall
                            state <= muscle_link_pkg::TX_IDLE;
                            ssel  <= 1'b1;
                            data  <= 1'b0;
                        end else begin
                            sck <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= muscle_link_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // payload shifter
    always_ff @(posedge ep50trig) begin
        if (state == muscle_link_pkg::TX_IDLE && tick) begin
            shreg <= payload;
        end else if (state == muscle_link_pkg::TX_SHIFT && half_done && sck) begin
            shreg <= {shreg[muscle_link_pkg::SPI_BITS-2:0], 1'b0};
        end
    end

endmodule

// File: logic/muscle_link_top.sv
module muscle_link_top (
    input  logic                   ep50trig,
    input  logic                   reset_global,

    // host apb port
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  muscle_link_pkg::addr_t paddr,
    input  muscle_link_pkg::word_t pwdata,
    output muscle_link_pkg::word_t prdata,
    output logic                   pready,
    output logic                   pslverr,

    // motor neuron spike from the pool model
    input  logic                   mn_spike,

    // muscle length in
    input  logic                   len_sck,
    input  logic                   len_ssel,
    input  logic                   len_data,

    // scaled rate out
    output logic                   rate_sck,
    output logic                   rate_ssel,
    output logic                   rate_data
);

    muscle_link_pkg::word_t  gain;
    muscle_link_pkg::half_t  tick_half;
    logic                    run;
    logic                    tick;
    muscle_link_pkg::count_t window_count;
    muscle_link_pkg::word_t  length;

    //////////////////////////////
    // apb pins into the bus
    //////////////////////////////

    apb_if bus ();

    // host drives the request half
    assign bus.psel    = psel;
    assign bus.penable = penable;
    assign bus.pwrite  = pwrite;
    assign bus.paddr   = paddr;
    assign bus.pwdata  = pwdata;
    assign prdata      = bus.prdata;
    assign pready      = bus.pready;
    assign pslverr     = bus.pslverr;

    //////////////////////////////
    // blocks
    //////////////////////////////

    param_regs param_regs_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .bus          (bus.slave),
        .length       (length),
        .gain         (gain),
        .tick_half    (tick_half),
        .run          (run)
    );

    sim_tick_gen sim_tick_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .run          (run),
        .tick_half    (tick_half),
        .tick         (tick)
    );

    spike_counter spike_counter_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .run          (run),
        .tick         (tick),
        .mn_spike     (mn_spike),
        .window_count (window_count)
    );

    spi_length_rx spi_length_rx_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .tick         (tick),
        .sck          (len_sck),
        .ssel         (len_ssel),
        .data         (len_data),
        .length       (length)
    );

    spi_rate_tx spi_rate_tx_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .tick         (tick),
        .window_count (window_count),
        .gain         (gain),
        .sck          (rate_sck),
        .ssel         (rate_ssel),
        .data         (rate_data)
    );

endmodule

// File: testbench/spi_peer.sv
module spi_peer (
    input  logic ep50trig,
    output logic len_sck,
    output logic len_ssel,
    output logic len_data,
    input  logic rate_sck,
    input  logic rate_ssel,
    input  logic rate_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // length master sck half period in clocks
    localparam int LEN_HALF_CLKS = 6;

    // decoded rate frames, oldest first
    muscle_link_pkg::word_t rate_words[$];
    int                     ssel_falls = 0;
    int                     bad_frames = 0;
    int                     rx_bits    = 0;
    muscle_link_pkg::word_t rx_shift   = '0;
    logic                   prev_ssel  = 1'b1;
    logic                   prev_sck   = 1'b0;

    //////////////////////////////
    // length master
    //////////////////////////////

    task automatic idle_lines();
        len_sck  = 1'b0;
        len_ssel = 1'b1;
        len_data = 1'b0;
    endtask

    // one 32 bit frame, msb first, data set a half period before sck rise
    task automatic send_length(input muscle_link_pkg::word_t word);
        @(negedge ep50trig);
        len_ssel = 1'b0;
        repeat (LEN_HALF_CLKS) @(negedge ep50trig);
        for (int i = muscle_link_pkg::SPI_BITS - 1; i >= 0; i--) begin
            len_data = word[i];
            repeat (LEN_HALF_CLKS) @(negedge ep50trig);
            len_sck = 1'b1;
            repeat (LEN_HALF_CLKS) @(negedge ep50trig);
            len_sck = 1'b0;
        end
        repeat (LEN_HALF_CLKS) @(negedge ep50trig);
        len_ssel = 1'b1;
        len_data = 1'b0;
        repeat (LEN_HALF_CLKS) @(negedge ep50trig);
    endtask

    //////////////////////////////
    // rate slave
    //////////////////////////////

    // rate pins move on the rising edge, so look at them on the falling one
    always @(negedge ep50trig) begin
        if (prev_ssel && !rate_ssel) begin
            ssel_falls++;
            rx_bits = 0;
        end
        if (!rate_ssel && rate_sck && !prev_sck) begin
            rx_shift = {rx_shift[muscle_link_pkg::SPI_BITS-2:0], rate_data};
            rx_bits++;
        end
        // frame end
        if (!prev_ssel && rate_ssel) begin
            if (rx_bits == muscle_link_pkg::SPI_BITS) begin
                rate_words.push_back(rx_shift);
            end else begin
                bad_frames++;
            end
        end
        prev_ssel = rate_ssel;
        prev_sck  = rate_sck;
    end

endmodule

// File: testbench/tb_muscle_link.sv
module tb_muscle_link;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS     = 8;
    localparam int RESET_CLKS = 16;
    // random tick half periods stay in 512..1023
    localparam int MAX_HALF   = 1023;
    localparam int LEN_WORDS  = 4;
    localparam int MAX_SPIKES = 36;
    // idle check, apb, length frames, spike windows, stop check, margin
    localparam int WATCHDOG_CLKS = RESET_CLKS + 4 * 1024 + 400
        + LEN_WORDS * (408 + 4 * MAX_HALF) + MAX_SPIKES * 86
        + 20 * MAX_HALF + 10 * MAX_HALF + 5000;

    logic                    ep50trig;
    logic                    reset_global;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    muscle_link_pkg::addr_t  paddr;
    muscle_link_pkg::word_t  pwdata;
    muscle_link_pkg::word_t  prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    mn_spike;
    logic                    len_sck;
    logic                    len_ssel;
    logic                    len_data;
    logic                    rate_sck;
    logic                    rate_ssel;
    logic                    rate_data;

    int seed   = 32'h16d1a06a;
    int checks = 0;
    int errors = 0;

    // model of the register bank and the traffic sent
    muscle_link_pkg::word_t exp_gain;
    muscle_link_pkg::word_t exp_half;
    muscle_link_pkg::word_t exp_len;
    muscle_link_pkg::word_t spikes_sent;
    int                     half_clks;

    muscle_link_top muscle_link_top_i (.*);
    spi_peer peer_i (.*);

    initial begin
        ep50trig = 1'b0;
        forever #(CLK_NS / 2) ep50trig = ~ep50trig;
    end

    initial begin
        #(WATCHDOG_CLKS * CLK_NS);
        errors++;
        $display("ERROR: watchdog expired after %0d clocks, a test never finished",
                 WATCHDOG_CLKS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic wait_clks(input int n);
        repeat (n) @(negedge ep50trig);
    endtask

    task automatic check_word(input string name, input muscle_link_pkg::word_t got,
                              input muscle_link_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok === 1'b1) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    // setup then access, response sampled mid access cycle
    task automatic apb_transfer(input logic write, input muscle_link_pkg::addr_t addr,
                                input muscle_link_pkg::word_t wdata,
                                output muscle_link_pkg::word_t rdata, output logic err);
        @(negedge ep50trig);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge ep50trig);
        penable = 1'b1;
        #2;
        rdata = prdata;
        err   = pslverr;
        @(negedge ep50trig);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input muscle_link_pkg::addr_t addr,
                             input muscle_link_pkg::word_t data, output logic err);
        muscle_link_pkg::word_t unused_rd;
        apb_transfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input muscle_link_pkg::addr_t addr,
                            output muscle_link_pkg::word_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        muscle_link_pkg::word_t rnd;
        muscle_link_pkg::word_t rd;
        muscle_link_pkg::word_t frame;
        muscle_link_pkg::word_t sum;
        muscle_link_pkg::addr_t bad_addr;
        logic                   err;
        int                     num_spikes;
        int                     zero_run;
        int                     falls;

        reset_global = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        mn_spike     = 1'b0;
        peer_i.idle_lines();
        exp_gain    = muscle_link_pkg::GAIN_RESET;
        exp_half    = muscle_link_pkg::word_t'(muscle_link_pkg::TICK_HALF_RESET);
        exp_len     = '0;
        spikes_sent = '0;
        wait_clks(RESET_CLKS);
        reset_global = 1'b0;

        // idle link out of reset, run off
        check_word("rate_ssel", {31'd0, rate_ssel}, 32'd1);
        check_word("rate_sck", {31'd0, rate_sck}, 32'd0);
        wait_clks(4 * 1024);
        check_true(peer_i.ssel_falls == 0, "rate frame sent while run is off");
        apb_read(muscle_link_pkg::REG_GAIN, rd, err);
        check_word("prdata gain", rd, exp_gain);
        check_word("pready", {31'd0, pready}, 32'd1);
        apb_read(muscle_link_pkg::REG_TICK_HALF, rd, err);
        check_word("prdata tick_half", rd, exp_half);
        apb_read(muscle_link_pkg::REG_CTRL, rd, err);
        check_word("prdata ctrl", rd, muscle_link_pkg::CTRL_RESET);
        apb_read(muscle_link_pkg::REG_LENGTH, rd, err);
        check_word("prdata length", rd, exp_len);
        check_word("pslverr", {31'd0, err}, 32'd0);

        // register write and readback, error responses
        repeat (6) begin
            rnd = $random(seed);
            apb_write(muscle_link_pkg::REG_GAIN, rnd, err);
            exp_gain = rnd;
            apb_read(muscle_link_pkg::REG_GAIN, rd, err);
            check_word("prdata gain", rd, exp_gain);
            rnd = $random(seed);
            exp_half = {23'd0, rnd[8:0]} + 32'd512;
            apb_write(muscle_link_pkg::REG_TICK_HALF, exp_half, err);
            apb_read(muscle_link_pkg::REG_TICK_HALF, rd, err);
            check_word("prdata tick_half", rd, exp_half);
            rnd = $random(seed);
            bad_addr = rnd[7:0] | 8'h10;
            apb_write(bad_addr, rnd, err);
            check_word("pslverr", {31'd0, err}, 32'd1);
            apb_read(bad_addr, rd, err);
            check_word("pslverr", {31'd0, err}, 32'd1);
            check_word("prdata unmapped", rd, 32'd0);
            apb_write(muscle_link_pkg::REG_LENGTH, rnd, err);
            check_word("pslverr", {31'd0, err}, 32'd1);
            apb_read(muscle_link_pkg::REG_LENGTH, rd, err);
            check_word("prdata length", rd, exp_len);
        end
        half_clks = int'(exp_half);

        // length words land on a tick
        apb_write(muscle_link_pkg::REG_CTRL, 32'd1, err);
        repeat (LEN_WORDS) begin
            rnd = $random(seed);
            peer_i.send_length(rnd);
            exp_len = rnd;
            wait_clks(4 * half_clks);
            apb_read(muscle_link_pkg::REG_LENGTH, rd, err);
            check_word("prdata length", rd, exp_len);
        end

        // scaled spike rate with a small gain
        rnd = $random(seed);
        exp_gain = {28'd0, rnd[3:0]} + 32'd1;
        apb_write(muscle_link_pkg::REG_GAIN, exp_gain, err);
        wait_clks(2);
        while (rate_ssel !== 1'b1) @(negedge ep50trig);
        peer_i.rate_words.delete();
        num_spikes = 5 + int'(rnd[8:4]);
        repeat (num_spikes) begin
            mn_spike = 1'b1;
            wait_clks(3);
            mn_spike = 1'b0;
            spikes_sent = spikes_sent + 32'd1;
            rnd = $random(seed);
            wait_clks(20 + int'(rnd[5:0]));
        end
        // three empty windows in a row mark the end of the activity
        zero_run = 0;
        sum      = '0;
        while (zero_run < 3) begin
            while (peer_i.rate_words.size() == 0) @(negedge ep50trig);
            frame = peer_i.rate_words.pop_front();
            sum   = sum + frame;
            if (frame == '0) begin
                zero_run++;
            end else begin
                zero_run = 0;
            end
        end
        check_word("rate payload sum", sum, exp_gain * spikes_sent);

        // run off, link goes quiet after the current frame
        apb_write(muscle_link_pkg::REG_CTRL, 32'd0, err);
        wait_clks(2);
        while (rate_ssel !== 1'b1) @(negedge ep50trig);
        #1;
        falls = peer_i.ssel_falls;
        wait_clks(8 * half_clks);
        #1;
        check_true(peer_i.ssel_falls == falls, "rate frame started after run was cleared");
        check_true(peer_i.bad_frames == 0, "rate frame with a bit count other than 32");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
logic/muscle_link_pkg.sv
logic/apb_if.sv
logic/param_regs.sv
logic/sim_tick_gen.sv
logic/spike_counter.sv
logic/spi_length_rx.sv
logic/spi_rate_tx.sv
logic/muscle_link_top.sv
testbench/spi_peer.sv
testbench/tb_muscle_link.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the muscle link testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_muscle_link -f src.f --Mdir obj_dir -o tb_muscle_link

./obj_dir/tb_muscle_link > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
